// ==== Bender.yml ====
package:
  name: pipe_top

sources:
  - cpu_pkg.sv
  - id_stage_if.sv
  - csr_port_if.sv
  - decode_stage.sv
  - id_ex_reg.sv
  - exec_stage.sv
  - csr_file.sv
  - pipe_top.sv
  - target: simulation
    files:
      - tb_pipe_top.sv

// ==== cpu_pkg.sv ====
package cpu_pkg;

    // widths that carry a meaning
    typedef logic [31:0] data_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [13:0] csr_addr_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [5:0]  opcode_t;

    // operation selected for the execute stage, addi folds into add
    typedef enum logic [3:0] {
        EX_NOP     = 4'd0,
        EX_ADD     = 4'd1,
        EX_SUB     = 4'd2,
        EX_AND     = 4'd3,
        EX_OR      = 4'd4,
        EX_XOR     = 4'd5,
        EX_SLT     = 4'd6,
        EX_CSRWR   = 4'd7,
        EX_SYSCALL = 4'd8,
        EX_ERTN    = 4'd9
    } ex_op_e;

    // major opcode in inst[31:26]
    localparam opcode_t OP_ADD     = 6'h01;
    localparam opcode_t OP_SUB     = 6'h02;
    localparam opcode_t OP_AND     = 6'h03;
    localparam opcode_t OP_OR      = 6'h04;
    localparam opcode_t OP_XOR     = 6'h05;
    localparam opcode_t OP_SLT     = 6'h06;
    localparam opcode_t OP_ADDI    = 6'h0a;
    localparam opcode_t OP_CSRWR   = 6'h10;
    localparam opcode_t OP_SYSCALL = 6'h15;
    localparam opcode_t OP_ERTN    = 6'h16;

    // csr numbers
    localparam csr_addr_t CSR_ESTAT = 14'h005;
    localparam csr_addr_t CSR_ERA   = 14'h006;
    localparam csr_addr_t CSR_SAVE0 = 14'h030;

    // exception codes, as stored in estat[21:16]
    localparam ecode_t ECODE_NONE = 6'h00;
    localparam ecode_t ECODE_SYS  = 6'h0b;
    localparam ecode_t ECODE_INE  = 6'h0d;

endpackage

// ==== csr_file.sv ====
module csr_file import cpu_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    csr_port_if.csr csr
);

    // only the ecode field of estat is implemented
    ecode_t estat_ecode;
    addr_t  era_q;
    data_t  save0_q;

    always_comb begin
        case (csr.raddr)
            CSR_ESTAT: csr.rdata = {10'd0, estat_ecode, 16'd0};
            CSR_ERA:   csr.rdata = era_q;
            CSR_SAVE0: csr.rdata = save0_q;
            default:   csr.rdata = '0;
        endcase
    end

    assign csr.era = era_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            estat_ecode <= ECODE_NONE;
            era_q       <= '0;
            save0_q     <= '0;
        end else if (csr.exc_en) begin
            // trap capture wins over a software write
            estat_ecode <= csr.exc_code;
            era_q       <= csr.exc_pc;
        end else if (csr.wen) begin
            case (csr.waddr)
                CSR_ESTAT: begin
                    estat_ecode <= csr.wdata[21:16];
                end
                CSR_ERA: begin
                    era_q <= csr.wdata;
                end
                CSR_SAVE0: begin
                    save0_q <= csr.wdata;
                end
                default: begin
                    // unknown number, write dropped
                end
            endcase
        end
    end

endmodule

// ==== csr_port_if.sv ====
interface csr_port_if import cpu_pkg::*; ();

    // combinational read
    csr_addr_t raddr;
    data_t     rdata;
    // write and exception capture, taken at the clock edge
    logic      wen;
    csr_addr_t waddr;
    data_t     wdata;
    logic      exc_en;
    addr_t     exc_pc;
    ecode_t    exc_code;
    // return address for ertn
    addr_t     era;

    modport exu (
        output raddr, wen, waddr, wdata, exc_en, exc_pc, exc_code,
        input  rdata, era
    );

    modport csr (
        input  raddr, wen, waddr, wdata, exc_en, exc_pc, exc_code,
        output rdata, era
    );

endinterface

// ==== decode_stage.sv ====
module decode_stage import cpu_pkg::*; (
    input  inst_t     inst,
    input  addr_t     pc,
    input  data_t     rj_data,
    input  data_t     rk_data,
    output reg_addr_t rj_addr,
    output reg_addr_t rk_addr,
    id_stage_if.o     dec
);

    opcode_t   opcode;
    reg_addr_t rd;
    logic [11:0] imm12;

    assign opcode  = inst[31:26];
    assign rd      = inst[4:0];
    assign imm12   = inst[21:10];
    assign rj_addr = inst[9:5];
    assign rk_addr = inst[14:10];

    always_comb begin
        // payload follows the instruction word directly
        dec.inst        = inst;
        dec.pc          = pc;
        dec.oprand1     = rj_data;
        dec.oprand2     = rk_data;
        dec.rw_addr     = rd;
        dec.csr_waddr   = {2'b00, imm12};
        dec.csr_wdata   = rj_data;
        dec.except_pc   = pc;
        dec.ex_op       = EX_NOP;
        dec.rw_en       = 1'b0;
        dec.except_type = ECODE_NONE;

        case (opcode)
            OP_ADD: begin
                dec.ex_op = EX_ADD;
                dec.rw_en = 1'b1;
            end
            OP_SUB: begin
                dec.ex_op = EX_SUB;
                dec.rw_en = 1'b1;
            end
            OP_AND: begin
                dec.ex_op = EX_AND;
                dec.rw_en = 1'b1;
            end
            OP_OR: begin
                dec.ex_op = EX_OR;
                dec.rw_en = 1'b1;
            end
            OP_XOR: begin
                dec.ex_op = EX_XOR;
                dec.rw_en = 1'b1;
            end
            OP_SLT: begin
                dec.ex_op = EX_SLT;
                dec.rw_en = 1'b1;
            end
            OP_ADDI: begin
                // sign-extended immediate replaces rk
                dec.ex_op   = EX_ADD;
                dec.rw_en   = 1'b1;
                dec.oprand2 = {{20{imm12[11]}}, imm12};
            end
            OP_CSRWR: begin
                dec.ex_op = EX_CSRWR;
                dec.rw_en = 1'b1;
            end
            OP_SYSCALL: begin
                dec.ex_op       = EX_SYSCALL;
                dec.except_type = ECODE_SYS;
            end
            OP_ERTN: begin
                dec.ex_op = EX_ERTN;
            end
            default: begin
                dec.except_type = ECODE_INE;
            end
        endcase
    end

endmodule

// ==== exec_stage.sv ====
module exec_stage import cpu_pkg::*; #(
    parameter addr_t EENTRY = 32'h1C00_0100
) (
    input  logic      fire,
    id_stage_if.i     ex_info,
    csr_port_if.exu   csr,
    output logic      wb_en,
    output reg_addr_t wb_addr,
    output data_t     wb_data,
    output logic      redirect_valid,
    output addr_t     redirect_pc
);

    data_t alu_res;
    logic  has_exc;
    logic  is_csrwr;

    assign has_exc  = ex_info.except_type != ECODE_NONE;
    assign is_csrwr = ex_info.ex_op == EX_CSRWR;

    always_comb begin
        case (ex_info.ex_op)
            EX_ADD:  alu_res = ex_info.oprand1 + ex_info.oprand2;
            EX_SUB:  alu_res = ex_info.oprand1 - ex_info.oprand2;
            EX_AND:  alu_res = ex_info.oprand1 & ex_info.oprand2;
            EX_OR:   alu_res = ex_info.oprand1 | ex_info.oprand2;
            EX_XOR:  alu_res = ex_info.oprand1 ^ ex_info.oprand2;
            EX_SLT:  alu_res = {31'd0, $signed(ex_info.oprand1) < $signed(ex_info.oprand2)};
            default: alu_res = '0;
        endcase
    end

    // csr swap reads the old value from the same number it writes
    assign csr.raddr    = ex_info.csr_waddr;
    assign csr.waddr    = ex_info.csr_waddr;
    assign csr.wdata    = ex_info.csr_wdata;
    assign csr.wen      = fire && is_csrwr && !has_exc;
    assign csr.exc_en   = fire && has_exc;
    assign csr.exc_pc   = ex_info.except_pc;
    assign csr.exc_code = ex_info.except_type;

    // rd 0 is never written
    assign wb_en   = fire && ex_info.rw_en && !has_exc && (ex_info.rw_addr != '0);
    assign wb_addr = fire ? ex_info.rw_addr : '0;
    assign wb_data = !fire ? '0 : (is_csrwr ? csr.rdata : alu_res);

    // traps go to the entry, ertn returns through era
    assign redirect_valid = fire && (has_exc || ex_info.ex_op == EX_ERTN);
    assign redirect_pc    = !fire ? '0 : (has_exc ? EENTRY : csr.era);

endmodule

// ==== id_ex_reg.sv ====
module id_ex_reg import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    output logic  in_ready,
    output logic  out_valid,
    input  logic  out_ready,
    input  logic  stall,
    input  logic  flush,
    id_stage_if.i id_info,
    id_stage_if.o ex_info
);

    logic valid_q;
    logic load;

    // stage can take a new item when empty or when its item leaves
    assign in_ready  = !valid_q || (out_ready && !stall);
    assign out_valid = valid_q && !stall;
    assign load      = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_info.inst        <= '0;
            ex_info.pc          <= '0;
            ex_info.oprand1     <= '0;
            ex_info.oprand2     <= '0;
            ex_info.ex_op       <= EX_NOP;
            ex_info.rw_addr     <= '0;
            ex_info.rw_en       <= 1'b0;
            ex_info.csr_waddr   <= '0;
            ex_info.csr_wdata   <= '0;
            ex_info.except_type <= ECODE_NONE;
            ex_info.except_pc   <= '0;
        end else if (flush) begin
            // kill the control fields, payload is don't care
            ex_info.ex_op       <= EX_NOP;
            ex_info.rw_en       <= 1'b0;
            ex_info.except_type <= ECODE_NONE;
        end else if (load) begin
            ex_info.inst        <= id_info.inst;
            ex_info.pc          <= id_info.pc;
            ex_info.oprand1     <= id_info.oprand1;
            ex_info.oprand2     <= id_info.oprand2;
            ex_info.ex_op       <= id_info.ex_op;
            ex_info.rw_addr     <= id_info.rw_addr;
            ex_info.rw_en       <= id_info.rw_en;
            ex_info.csr_waddr   <= id_info.csr_waddr;
            ex_info.csr_wdata   <= id_info.csr_wdata;
            ex_info.except_type <= id_info.except_type;
            ex_info.except_pc   <= id_info.except_pc;
        end
    end

endmodule

// ==== id_stage_if.sv ====
interface id_stage_if import cpu_pkg::*; ();

    inst_t     inst;
    addr_t     pc;
    data_t     oprand1;
    data_t     oprand2;
    ex_op_e    ex_op;
    reg_addr_t rw_addr;
    logic      rw_en;
    csr_addr_t csr_waddr;
    data_t     csr_wdata;
    // nonzero code means the instruction traps
    ecode_t    except_type;
    addr_t     except_pc;

    modport i (
        input inst, pc, oprand1, oprand2, ex_op, rw_addr, rw_en,
        input csr_waddr, csr_wdata, except_type, except_pc
    );

    modport o (
        output inst, pc, oprand1, oprand2, ex_op, rw_addr, rw_en,
        output csr_waddr, csr_wdata, except_type, except_pc
    );

endinterface

// ==== pipe_top.sv ====
module pipe_top import cpu_pkg::*; #(
    parameter addr_t EENTRY = 32'h1C00_0100
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    output logic      in_ready,
    input  inst_t     inst,
    input  addr_t     pc,
    output reg_addr_t rj_addr,
    output reg_addr_t rk_addr,
    input  data_t     rj_data,
    input  data_t     rk_data,
    output logic      out_valid,
    input  logic      out_ready,
    input  logic      stall,
    input  logic      flush,
    output logic      wb_en,
    output reg_addr_t wb_addr,
    output data_t     wb_data,
    output logic      redirect_valid,
    output addr_t     redirect_pc
);

    logic fire;

    id_stage_if i_dec_if ();
    id_stage_if i_ex_if ();
    csr_port_if i_csr_if ();

    // commit beat for execute and the csr file
    assign fire = out_valid && out_ready;

    decode_stage i_decode_stage (
        .inst    (inst),
        .pc      (pc),
        .rj_data (rj_data),
        .rk_data (rk_data),
        .rj_addr (rj_addr),
        .rk_addr (rk_addr),
        .dec     (i_dec_if.o)
    );

    id_ex_reg i_id_ex_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .stall     (stall),
        .flush     (flush),
        .id_info   (i_dec_if.i),
        .ex_info   (i_ex_if.o)
    );

    exec_stage #(
        .EENTRY (EENTRY)
    ) i_exec_stage (
        .fire           (fire),
        .ex_info        (i_ex_if.i),
        .csr            (i_csr_if.exu),
        .wb_en          (wb_en),
        .wb_addr        (wb_addr),
        .wb_data        (wb_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    csr_file i_csr_file (
        .clk   (clk),
        .rst_n (rst_n),
        .csr   (i_csr_if.csr)
    );

endmodule

// ==== sim.f ====
cpu_pkg.sv
id_stage_if.sv
csr_port_if.sv
decode_stage.sv
id_ex_reg.sv
exec_stage.sv
csr_file.sv
pipe_top.sv
tb_pipe_top.sv

// ==== tb_pipe_top.sv ====
module tb_pipe_top import cpu_pkg::*; ();

    localparam addr_t EENTRY          = 32'h1C00_0100;
    localparam int    TEST_COUNT      = 6;
    localparam int    CYCLES_PER_TEST = 200;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    logic      in_ready;
    inst_t     inst;
    addr_t     pc;
    reg_addr_t rj_addr;
    reg_addr_t rk_addr;
    data_t     rj_data;
    data_t     rk_data;
    logic      out_valid;
    logic      out_ready;
    logic      stall;
    logic      flush;
    logic      wb_en;
    reg_addr_t wb_addr;
    data_t     wb_data;
    logic      redirect_valid;
    addr_t     redirect_pc;

    // shadow of the csr file
    data_t shadow_estat;
    data_t shadow_era;
    data_t shadow_save0;
    int unsigned seed;

    pipe_top i_pipe_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .inst           (inst),
        .pc             (pc),
        .rj_addr        (rj_addr),
        .rk_addr        (rk_addr),
        .rj_data        (rj_data),
        .rk_data        (rk_data),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .stall          (stall),
        .flush          (flush),
        .wb_en          (wb_en),
        .wb_addr        (wb_addr),
        .wb_data        (wb_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (TEST_COUNT * CYCLES_PER_TEST + 3) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles",
                 TEST_COUNT * CYCLES_PER_TEST);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic report_mismatch(string what, logic [31:0] got, logic [31:0] exp);
        $display("FAIL at %0t: %s is %h, expected %h", $time, what, got, exp);
        $display(">>> FAIL");
        $fatal(1, "value mismatch");
    endtask

    task automatic check_data(string what, data_t got, data_t exp);
        if (got !== exp) report_mismatch(what, got, exp);
    endtask

    task automatic check_addr(string what, addr_t got, addr_t exp);
        if (got !== exp) report_mismatch(what, got, exp);
    endtask

    task automatic check_reg(string what, reg_addr_t got, reg_addr_t exp);
        if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
    endtask

    task automatic check_bit(string what, logic got, logic exp);
        if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
    endtask

    function automatic inst_t reg_inst(opcode_t op, reg_addr_t rd, reg_addr_t rj,
                                       reg_addr_t rk);
        return {op, 11'd0, rk, rj, rd};
    endfunction

    function automatic inst_t imm_inst(opcode_t op, reg_addr_t rd, reg_addr_t rj,
                                       logic [11:0] imm);
        return {op, 4'd0, imm, rj, rd};
    endfunction

    function automatic data_t alu_model(opcode_t op, data_t a, data_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_ADDI: return a + {{20{b[11]}}, b[11:0]};
            default: return '0;
        endcase
    endfunction

    function automatic data_t csr_read_model(csr_addr_t num);
        case (num)
            CSR_ESTAT: return shadow_estat;
            CSR_ERA:   return shadow_era;
            CSR_SAVE0: return shadow_save0;
            default:   return '0;
        endcase
    endfunction

    task automatic csr_write_model(csr_addr_t num, data_t v);
        case (num)
            CSR_ESTAT: shadow_estat = v & 32'h003f_0000;
            CSR_ERA:   shadow_era = v;
            CSR_SAVE0: shadow_save0 = v;
            default:   ;
        endcase
    endtask

    // present one instruction, return on the falling edge after acceptance
    task automatic issue(inst_t word, addr_t at_pc, data_t a, data_t b);
        in_valid = 1'b1;
        inst     = word;
        pc       = at_pc;
        rj_data  = a;
        rk_data  = b;
        #1;
        check_reg("rj_addr", rj_addr, word[9:5]);
        check_reg("rk_addr", rk_addr, word[14:10]);
        while (!in_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic check_commit(logic exp_wb, reg_addr_t exp_addr, data_t exp_data,
                                logic exp_redir, addr_t exp_pc);
        #1;
        while (!(out_valid && out_ready)) begin
            @(negedge clk);
            #1;
        end
        check_bit("wb_en", wb_en, exp_wb);
        if (exp_wb) begin
            check_reg("wb_addr", wb_addr, exp_addr);
            check_data("wb_data", wb_data, exp_data);
        end
        check_bit("redirect_valid", redirect_valid, exp_redir);
        if (exp_redir) check_addr("redirect_pc", redirect_pc, exp_pc);
        @(negedge clk);
    endtask

    task automatic run_alu(opcode_t op, reg_addr_t rd, data_t a, data_t b, addr_t at_pc);
        inst_t word;
        word = (op == OP_ADDI) ? imm_inst(op, rd, 5'd1, b[11:0]) : reg_inst(op, rd, 5'd1, 5'd2);
        issue(word, at_pc, a, b);
        check_commit(rd != 5'd0, rd, alu_model(op, a, b), 1'b0, '0);
    endtask

    task automatic csr_swap(csr_addr_t num, reg_addr_t rd, data_t v, addr_t at_pc);
        data_t old;
        old = csr_read_model(num);
        issue(imm_inst(OP_CSRWR, rd, 5'd4, num[11:0]), at_pc, v, '0);
        check_commit(rd != 5'd0, rd, old, 1'b0, '0);
        csr_write_model(num, v);
    endtask

    task automatic test_reset_and_add();
        #1;
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("wb_en", wb_en, 1'b0);
        check_bit("redirect_valid", redirect_valid, 1'b0);
        check_bit("in_ready", in_ready, 1'b1);
        @(negedge clk);
        issue(reg_inst(OP_ADD, 5'd3, 5'd1, 5'd2), 32'h1c00_0000, 32'd1234, 32'd4321);
        // item must be visible one cycle after acceptance
        #1;
        check_bit("out_valid", out_valid, 1'b1);
        check_commit(1'b1, 5'd3, 32'd5555, 1'b0, '0);
    endtask

    task automatic test_random_alu();
        opcode_t   ops [7];
        opcode_t   op;
        reg_addr_t rd;
        ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_ADDI};
        for (int n = 0; n < 24; n++) begin
            op = ops[$urandom % 7];
            rd = (n % 6 == 0) ? 5'd0 : reg_addr_t'($urandom);
            run_alu(op, rd, $urandom, $urandom, 32'h1c00_0100 + 32'(n * 4));
        end
    endtask

    task automatic test_backpressure();
        out_ready = 1'b0;
        issue(reg_inst(OP_SUB, 5'd8, 5'd1, 5'd2), 32'h1c00_1000, 32'd100, 32'd30);
        issue_pending(reg_inst(OP_XOR, 5'd9, 5'd1, 5'd2), 32'h1c00_1004);
        repeat (3) begin
            #1;
            check_bit("in_ready", in_ready, 1'b0);
            check_bit("out_valid", out_valid, 1'b1);
            check_bit("wb_en", wb_en, 1'b0);
            @(negedge clk);
        end
        stall     = 1'b1;
        out_ready = 1'b1;
        repeat (2) begin
            #1;
            check_bit("out_valid", out_valid, 1'b0);
            check_bit("in_ready", in_ready, 1'b0);
            check_bit("wb_en", wb_en, 1'b0);
            @(negedge clk);
        end
        stall = 1'b0;
        check_commit(1'b1, 5'd8, 32'd70, 1'b0, '0);
        // second item was taken on the first one's commit edge
        in_valid = 1'b0;
        check_commit(1'b1, 5'd9, 32'hff00_ffff, 1'b0, '0);
        #1;
        check_bit("out_valid", out_valid, 1'b0);
        @(negedge clk);
    endtask

    // drive an instruction without waiting for acceptance
    task automatic issue_pending(inst_t word, addr_t at_pc);
        in_valid = 1'b1;
        inst     = word;
        pc       = at_pc;
        rj_data  = 32'hffff_0f0f;
        rk_data  = 32'h00ff_f0f0;
    endtask

    task automatic test_flush();
        out_ready = 1'b0;
        issue(reg_inst(OP_ADD, 5'd5, 5'd1, 5'd2), 32'h1c00_2000, 32'd7, 32'd8);
        flush = 1'b1;
        #1;
        check_bit("out_valid", out_valid, 1'b1);
        @(negedge clk);
        flush     = 1'b0;
        out_ready = 1'b1;
        repeat (3) begin
            #1;
            check_bit("out_valid", out_valid, 1'b0);
            check_bit("wb_en", wb_en, 1'b0);
            @(negedge clk);
        end
    endtask

    task automatic test_csr_swap();
        csr_swap(CSR_SAVE0, 5'd6, 32'hcafe_0001, 32'h1c00_3000);
        csr_swap(CSR_SAVE0, 5'd6, 32'h1234_5678, 32'h1c00_3004);
        csr_swap(14'h123, 5'd6, 32'hdead_beef, 32'h1c00_3008);
    endtask

    task automatic test_trap_and_return();
        addr_t p;
        addr_t q;
        p = 32'h1c00_4010;
        q = 32'h1c00_4abc;
        issue(reg_inst(OP_SYSCALL, 5'd0, 5'd0, 5'd0), p, '0, '0);
        check_commit(1'b0, '0, '0, 1'b1, EENTRY);
        shadow_era   = p;
        shadow_estat = {10'd0, ECODE_SYS, 16'd0};
        csr_swap(CSR_ESTAT, 5'd7, 32'h0000_0000, EENTRY);
        issue(reg_inst(OP_ERTN, 5'd0, 5'd0, 5'd0), EENTRY + 4, '0, '0);
        check_commit(1'b0, '0, '0, 1'b1, p);
        // undefined major opcode
        issue({6'h3f, 26'h0000_123}, q, '0, '0);
        check_commit(1'b0, '0, '0, 1'b1, EENTRY);
        shadow_era   = q;
        shadow_estat = {10'd0, ECODE_INE, 16'd0};
        csr_swap(CSR_ERA, 5'd9, 32'h0000_0000, EENTRY);
    endtask

    initial begin
        seed = 32'h3ad3f81d;
        void'($urandom(seed));
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        inst         = '0;
        pc           = '0;
        rj_data      = '0;
        rk_data      = '0;
        out_ready    = 1'b1;
        stall        = 1'b0;
        flush        = 1'b0;
        shadow_estat = '0;
        shadow_era   = '0;
        shadow_save0 = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        test_reset_and_add();
        test_random_alu();
        test_backpressure();
        test_flush();
        test_csr_swap();
        test_trap_and_return();
        $display(">>> PASS");
        $finish;
    end

endmodule
